// File: design/recon_consts.svh
`ifndef RECON_CONSTS_SVH
`define RECON_CONSTS_SVH

// ----------------------------------------
// Grid geometry
// ----------------------------------------

// Cells per grid side.
`define RECON_GRID_DIM     40

// Bits per X or Y coordinate.
`define RECON_COORD_W      8

// ----------------------------------------
// Path store
// ----------------------------------------

`define RECON_MAX_PATH     40                       // Entries in the path buffer.
`define RECON_EMPTY_COORD  {`RECON_COORD_W{1'b1}}   // Unused entry value.

`endif

// File: design/grid_pkg.sv
`default_nettype none

`include "recon_consts.svh"

// Coordinate types shared by the table, the path store and the top level.
package grid_pkg;

   // ----------------------------------------
   // Cell coordinates
   // ----------------------------------------

   // One X or one Y.
   typedef logic [`RECON_COORD_W-1:0] coord_t;

endpackage

`default_nettype wire

// File: design/recon_pkg.sv
`default_nettype none

`include "recon_consts.svh"

// Control types of the backtracking engine.
package recon_pkg;

   // ----------------------------------------
   // Controller states
   // ----------------------------------------

   typedef enum logic [2:0]
   {
      IDLE,                 // Waiting for start.
      INIT,                 // Clear buffer, load cursor.
      LOOKUP,               // Record one predecessor.
      CHECK,                // Origin or full test.
      DONE                  // One-cycle completion.
   } recon_state_t;

   // Slot index or path length, wide enough for RECON_MAX_PATH.
   typedef logic [$clog2(`RECON_MAX_PATH + 1)-1:0] path_idx_t;

endpackage

`default_nettype wire

// File: design/pred_table.sv
`default_nettype none

`include "recon_consts.svh"

module pred_table
(
   input  logic             Clk,
   input  logic             Reset,
   input  logic             load_en,
   input  grid_pkg::coord_t load_x,
   input  grid_pkg::coord_t load_y,
   input  grid_pkg::coord_t load_prev_x,
   input  grid_pkg::coord_t load_prev_y,
   input  logic             clear,
   input  logic             record,
   input  grid_pkg::coord_t goal_x,
   input  grid_pkg::coord_t goal_y,
   output grid_pkg::coord_t prev_x,
   output grid_pkg::coord_t prev_y,
   output logic             at_origin
);
   import grid_pkg::*;

   localparam int CELL_W = $clog2(`RECON_GRID_DIM);

   // Predecessor planes, indexed [x][y].
   coord_t plane_x [`RECON_GRID_DIM][`RECON_GRID_DIM];
   coord_t plane_y [`RECON_GRID_DIM][`RECON_GRID_DIM];

   coord_t            cur_x;               // Trace cursor.
   coord_t            cur_y;
   logic [CELL_W-1:0] cur_xi;
   logic [CELL_W-1:0] cur_yi;
   logic [CELL_W-1:0] load_xi;
   logic [CELL_W-1:0] load_yi;

   assign cur_xi  = cur_x[CELL_W-1:0];     // Upper bits are zero inside the grid.
   assign cur_yi  = cur_y[CELL_W-1:0];
   assign load_xi = load_x[CELL_W-1:0];
   assign load_yi = load_y[CELL_W-1:0];

   // ----------------------------------------
   // Table write port
   // ----------------------------------------

   always_ff @(posedge Clk)
   begin
      if (load_en)
      begin
         plane_x[load_xi][load_yi] <= load_prev_x;
         plane_y[load_xi][load_yi] <= load_prev_y;
      end
   end

   // ----------------------------------------
   // Cursor
   // ----------------------------------------

   always_ff @(posedge Clk or posedge Reset)
   begin
      if (Reset)
      begin
         cur_x <= '0;
         cur_y <= '0;
      end
      else if (clear)
      begin
         cur_x <= goal_x;                  // Trace starts at the goal.
         cur_y <= goal_y;
      end
      else if (record)
      begin
         cur_x <= prev_x;                  // One hop back.
         cur_y <= prev_y;
      end
   end

   assign prev_x    = plane_x[cur_xi][cur_yi];
   assign prev_y    = plane_y[cur_xi][cur_yi];
   assign at_origin = (cur_x == '0) && (cur_y == '0);

   // The walk only ever visits cells that the table describes.
   a_cursor_in_grid : assert property (@(posedge Clk) disable iff (Reset)
      (cur_x < `RECON_GRID_DIM) && (cur_y < `RECON_GRID_DIM));

   a_load_in_grid : assert property (@(posedge Clk) disable iff (Reset)
      load_en |-> (load_x < `RECON_GRID_DIM) && (load_y < `RECON_GRID_DIM));

   a_no_load_during_trace : assert property (@(posedge Clk) disable iff (Reset)
      !(load_en && record));

endmodule

`default_nettype wire

// File: design/step_counter.sv
`default_nettype none

`include "recon_consts.svh"

module step_counter
(
   input  logic                 Clk,
   input  logic                 Reset,
   input  logic                 clear,
   input  logic                 advance,
   output recon_pkg::path_idx_t index,
   output logic                 full
);
   import recon_pkg::*;

   // ----------------------------------------
   // Slot counter
   // ----------------------------------------

   always_ff @(posedge Clk or posedge Reset)
   begin
      if (Reset)
      begin
         index <= '0;
      end
      else if (clear)
      begin
         index <= '0;                      // New run.
      end
      else if (advance)
      begin
         index <= index + path_idx_t'(1);
      end
   end

   // Last slot of the path buffer reached.
   assign full = (index == path_idx_t'(`RECON_MAX_PATH - 1));

   // The controller stops stepping once the last slot is in use.
   a_no_advance_when_full : assert property (@(posedge Clk) disable iff (Reset)
      advance |-> !full);

endmodule

`default_nettype wire

// File: design/path_buffer.sv
`default_nettype none

`include "recon_consts.svh"

module path_buffer
(
   input  logic                 Clk,
   input  logic                 Reset,
   input  logic                 clear,
   input  logic                 record,
   input  recon_pkg::path_idx_t index,
   input  recon_pkg::path_idx_t read_index,
   input  grid_pkg::coord_t     entry_x,
   input  grid_pkg::coord_t     entry_y,
   output grid_pkg::coord_t     read_x,
   output grid_pkg::coord_t     read_y
);
   import grid_pkg::*;
   import recon_pkg::*;

   // Finished path, entry 0 is the goal's predecessor.
   coord_t path_x [`RECON_MAX_PATH];
   coord_t path_y [`RECON_MAX_PATH];

   logic   read_valid;

   // ----------------------------------------
   // Fill and write
   // ----------------------------------------

   always_ff @(posedge Clk or posedge Reset)
   begin
      if (Reset)
      begin
         for (int i = 0; i < `RECON_MAX_PATH; i++)
         begin
            path_x[i] <= `RECON_EMPTY_COORD;
            path_y[i] <= `RECON_EMPTY_COORD;
         end
      end
      else if (clear)
      begin
         // Stale entries of a longer run must not survive.
         for (int i = 0; i < `RECON_MAX_PATH; i++)
         begin
            path_x[i] <= `RECON_EMPTY_COORD;
            path_y[i] <= `RECON_EMPTY_COORD;
         end
      end
      else if (record)
      begin
         path_x[index] <= entry_x;
         path_y[index] <= entry_y;
      end
   end

   // ----------------------------------------
   // Read port
   // ----------------------------------------

   assign read_valid = (read_index < path_idx_t'(`RECON_MAX_PATH));

   assign read_x = read_valid ? path_x[read_index] : `RECON_EMPTY_COORD;  // Beyond the end.
   assign read_y = read_valid ? path_y[read_index] : `RECON_EMPTY_COORD;

endmodule

`default_nettype wire

// File: design/recon_fsm.sv
`default_nettype none

module recon_fsm
(
   input  logic                 Clk,
   input  logic                 Reset,
   input  logic                 start,
   input  logic                 at_origin,
   input  logic                 full,
   output logic                 clear,
   output logic                 record,
   output logic                 advance,
   output logic                 busy,
   output logic                 done,
   output logic                 overflow,
   output recon_pkg::path_idx_t path_len
);
   import recon_pkg::*;

   recon_state_t state;
   recon_state_t next_state;

   // ----------------------------------------
   // State register and next state
   // ----------------------------------------

   always_ff @(posedge Clk or posedge Reset)
   begin
      if (Reset)
         state <= IDLE;
      else
         state <= next_state;
   end

   always_comb
   begin
      next_state = state;
      case (state)
         IDLE:    if (start) next_state = INIT;    // Start is ignored in other states.
         INIT:    next_state = LOOKUP;
         LOOKUP:  next_state = CHECK;
         CHECK:   next_state = (at_origin || full) ? DONE : LOOKUP;
         DONE:    next_state = IDLE;
         default: next_state = IDLE;
      endcase
   end

   // ----------------------------------------
   // Strobes and status
   // ----------------------------------------

   assign clear   = (state == INIT);
   assign record  = (state == LOOKUP);
   assign advance = (state == CHECK) && !at_origin && !full;
   assign busy    = (state != IDLE);
   assign done    = (state == DONE);

   always_ff @(posedge Clk or posedge Reset)
   begin
      if (Reset)
      begin
         overflow <= 1'b0;
         path_len <= '0;
      end
      else
      begin
         if (clear)
            overflow <= 1'b0;
         else if ((state == CHECK) && full && !at_origin)
            overflow <= 1'b1;                      // Buffer ran out first.

         if (clear)
            path_len <= '0;
         else if (record)
            path_len <= path_len + path_idx_t'(1);
      end
   end

   // Completion is a one-cycle pulse after at least one hop.
   a_done_pulse : assert property (@(posedge Clk) disable iff (Reset)
      done |=> !done && (path_len != '0));

   // A hop is recorded only after INIT or a CHECK that chose to continue.
   a_record_in_lookup : assert property (@(posedge Clk) disable iff (Reset)
      record |-> $past(clear || advance));

endmodule

`default_nettype wire

// File: design/path_recon.sv
`default_nettype none

module path_recon
(
   input  logic                 Clk,
   input  logic                 Reset,
   input  logic                 load_en,
   input  grid_pkg::coord_t     load_x,
   input  grid_pkg::coord_t     load_y,
   input  grid_pkg::coord_t     load_prev_x,
   input  grid_pkg::coord_t     load_prev_y,
   input  logic                 start,
   input  grid_pkg::coord_t     goal_x,
   input  grid_pkg::coord_t     goal_y,
   input  recon_pkg::path_idx_t read_index,
   output logic                 busy,
   output logic                 done,
   output logic                 overflow,
   output recon_pkg::path_idx_t path_len,
   output grid_pkg::coord_t     read_x,
   output grid_pkg::coord_t     read_y
);
   import grid_pkg::*;
   import recon_pkg::*;

   logic      clear;
   logic      record;
   logic      advance;
   logic      at_origin;
   logic      full;
   coord_t    prev_x;                      // Predecessor of the cursor.
   coord_t    prev_y;
   path_idx_t index;

   // ----------------------------------------
   // Datapath
   // ----------------------------------------

   pred_table table0
   (
      .Clk         (Clk),
      .Reset       (Reset),
      .load_en     (load_en),
      .load_x      (load_x),
      .load_y      (load_y),
      .load_prev_x (load_prev_x),
      .load_prev_y (load_prev_y),
      .clear       (clear),
      .record      (record),
      .goal_x      (goal_x),
      .goal_y      (goal_y),
      .prev_x      (prev_x),
      .prev_y      (prev_y),
      .at_origin   (at_origin)
   );

   step_counter counter0
   (
      .Clk     (Clk),
      .Reset   (Reset),
      .clear   (clear),
      .advance (advance),
      .index   (index),
      .full    (full)
   );

   path_buffer buffer0
   (
      .Clk        (Clk),
      .Reset      (Reset),
      .clear      (clear),
      .record     (record),
      .index      (index),
      .read_index (read_index),
      .entry_x    (prev_x),
      .entry_y    (prev_y),
      .read_x     (read_x),
      .read_y     (read_y)
   );

   // ----------------------------------------
   // Control
   // ----------------------------------------

   recon_fsm fsm0
   (
      .Clk       (Clk),
      .Reset     (Reset),
      .start     (start),
      .at_origin (at_origin),
      .full      (full),
      .clear     (clear),
      .record    (record),
      .advance   (advance),
      .busy      (busy),
      .done      (done),
      .overflow  (overflow),
      .path_len  (path_len)
   );

endmodule

`default_nettype wire

// File: testbench/tb_path_recon.sv
`default_nettype none

`include "recon_consts.svh"

module tb_path_recon;
   import grid_pkg::*;
   import recon_pkg::*;

   localparam int TIMEOUT_CYCLES = 20000;
   localparam int NUM_CHAINS     = 30;
   localparam int NUM_READS      = 1 << $bits(path_idx_t);   // Whole index range.

   logic      Clk;
   logic      Reset;
   logic      load_en;
   coord_t    load_x;
   coord_t    load_y;
   coord_t    load_prev_x;
   coord_t    load_prev_y;
   logic      start;
   coord_t    goal_x;
   coord_t    goal_y;
   path_idx_t read_index;
   logic      busy;
   logic      done;
   logic      overflow;
   path_idx_t path_len;
   coord_t    read_x;
   coord_t    read_y;

   // Reference copy of the table and the expected path.
   coord_t model_px [`RECON_GRID_DIM][`RECON_GRID_DIM];
   coord_t model_py [`RECON_GRID_DIM][`RECON_GRID_DIM];
   coord_t exp_x [`RECON_MAX_PATH];
   coord_t exp_y [`RECON_MAX_PATH];
   int     exp_len;
   logic   exp_overflow;

   integer seed = 5357;
   int     cycle_count = 0;
   int     run_cycles;

   path_recon dut0
   (
      .Clk         (Clk),
      .Reset       (Reset),
      .load_en     (load_en),
      .load_x      (load_x),
      .load_y      (load_y),
      .load_prev_x (load_prev_x),
      .load_prev_y (load_prev_y),
      .start       (start),
      .goal_x      (goal_x),
      .goal_y      (goal_y),
      .read_index  (read_index),
      .busy        (busy),
      .done        (done),
      .overflow    (overflow),
      .path_len    (path_len),
      .read_x      (read_x),
      .read_y      (read_y)
   );

   // ----------------------------------------
   // Clock and timeout
   // ----------------------------------------

   initial Clk = 1'b0;
   always #10 Clk = ~Clk;

   always @(posedge Clk)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
         $display("Timeout: the test did not finish within %0d cycles", cycle_count);
         $display("Regression failed");
         $fatal(1);
      end
   end

   // ----------------------------------------
   // Helpers
   // ----------------------------------------

   task automatic stop_on_error(input string line);
      $display("%s", line);
      $display("Regression failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input int actual, input int expected);
      assert (actual == expected)
      else stop_on_error($sformatf("Error at time %0t: %s is %0d, expected %0d",
                                   $time, name, actual, expected));
   endtask

   // One table write per cycle, mirrored into the model.
   task automatic load_cell(input int x, input int y, input int px, input int py);
      @(negedge Clk);
      load_en     = 1'b1;
      load_x      = coord_t'(x);
      load_y      = coord_t'(y);
      load_prev_x = coord_t'(px);
      load_prev_y = coord_t'(py);
      model_px[x][y] = coord_t'(px);
      model_py[x][y] = coord_t'(py);
   endtask

   // Walk back from the goal until the origin or a full buffer.
   task automatic walk_model(input int gx, input int gy);
      int cx;
      int cy;
      cx      = gx;
      cy      = gy;
      exp_len = 0;
      do
      begin
         exp_x[exp_len] = model_px[cx][cy];
         exp_y[exp_len] = model_py[cx][cy];
         cx = int'(exp_x[exp_len]);
         cy = int'(exp_y[exp_len]);
         exp_len++;
      end
      while (!(cx == 0 && cy == 0) && exp_len < `RECON_MAX_PATH);
      exp_overflow = !(cx == 0 && cy == 0);
   endtask

   // Distinct cells, goal first, ending at the origin.
   task automatic load_random_chain(input int hops, output int gx, output int gy);
      int cx [`RECON_MAX_PATH + 1];
      int cy [`RECON_MAX_PATH + 1];
      bit used [`RECON_GRID_DIM][`RECON_GRID_DIM];
      int x;
      int y;
      for (int i = 0; i < `RECON_GRID_DIM; i++)
      begin
         for (int j = 0; j < `RECON_GRID_DIM; j++)
            used[i][j] = 1'b0;
      end
      used[0][0] = 1'b1;
      for (int k = 0; k < hops; k++)
      begin
         do
         begin
            x = int'($unsigned($random(seed)) % `RECON_GRID_DIM);
            y = int'($unsigned($random(seed)) % `RECON_GRID_DIM);
         end
         while (used[x][y]);
         used[x][y] = 1'b1;
         cx[k] = x;
         cy[k] = y;
      end
      cx[hops] = 0;
      cy[hops] = 0;
      for (int k = 0; k < hops; k++)
         load_cell(cx[k], cy[k], cx[k + 1], cy[k + 1]);
      gx = cx[0];
      gy = cy[0];
   endtask

   // Start a trace and wait for done. A nonzero extra_at pulses start again mid-run.
   task automatic run_trace(input int gx, input int gy, input int extra_at,
                            input int extra_gx, input int extra_gy);
      walk_model(gx, gy);
      @(negedge Clk);
      load_en = 1'b0;
      goal_x  = coord_t'(gx);
      goal_y  = coord_t'(gy);
      start   = 1'b1;
      @(negedge Clk);
      start      = 1'b0;
      run_cycles = 1;                       // The strobe cycle counts as one.
      while (!done)
      begin
         check_value("busy", int'(busy), 1);
         @(negedge Clk);
         run_cycles++;
         if (run_cycles == extra_at)
         begin
            start  = 1'b1;                  // Must be ignored.
            goal_x = coord_t'(extra_gx);
            goal_y = coord_t'(extra_gy);
         end
         else
            start = 1'b0;
      end
      start = 1'b0;
      check_value("cycles from start to done", run_cycles, 2 * exp_len + 2);
      check_value("overflow", int'(overflow), int'(exp_overflow));
      check_value("path_len", int'(path_len), exp_len);
      @(negedge Clk);
      check_value("done", int'(done), 0);   // Pulse, then idle.
      check_value("busy", int'(busy), 0);
   endtask

   // Entries below exp_len hold the path, the rest read all ones.
   task automatic check_path();
      coord_t want_x;
      coord_t want_y;
      for (int i = 0; i < NUM_READS; i++)
      begin
         @(negedge Clk);
         read_index = path_idx_t'(i);
         #1;
         if (i < exp_len)
         begin
            want_x = exp_x[i];
            want_y = exp_y[i];
         end
         else
         begin
            want_x = `RECON_EMPTY_COORD;
            want_y = `RECON_EMPTY_COORD;
         end
         check_value($sformatf("read_x[%0d]", i), int'(read_x), int'(want_x));
         check_value($sformatf("read_y[%0d]", i), int'(read_y), int'(want_y));
      end
   endtask

   // ----------------------------------------
   // Test sequence
   // ----------------------------------------

   initial
   begin
      int gx;
      int gy;
      int hops;
      Reset       = 1'b1;
      load_en     = 1'b0;
      load_x      = '0;
      load_y      = '0;
      load_prev_x = '0;
      load_prev_y = '0;
      start       = 1'b0;
      goal_x      = '0;
      goal_y      = '0;
      read_index  = '0;
      repeat (3) @(posedge Clk);
      @(negedge Clk);
      Reset = 1'b0;

      // State after reset.
      check_value("busy", int'(busy), 0);
      check_value("done", int'(done), 0);
      check_value("overflow", int'(overflow), 0);
      check_value("path_len", int'(path_len), 0);
      exp_len = 0;
      check_path();

      for (int x = 0; x < `RECON_GRID_DIM; x++)
      begin
         for (int y = 0; y < `RECON_GRID_DIM; y++)
            load_cell(x, y, 0, 0);
      end

      // Single hop to the origin.
      run_trace(5, 7, 0, 0, 0);
      check_value("path_len", int'(path_len), 1);
      check_path();

      for (int t = 0; t < NUM_CHAINS; t++)
      begin
         hops = 1 + int'($unsigned($random(seed)) % (`RECON_MAX_PATH - 1));
         load_random_chain(hops, gx, gy);
         run_trace(gx, gy, 0, 0, 0);
         check_value("path_len", int'(path_len), hops);
         check_path();
      end

      // Loop that never reaches the origin.
      load_cell(3, 4, 10, 20);
      load_cell(10, 20, 39, 39);
      load_cell(39, 39, 3, 4);
      run_trace(3, 4, 0, 0, 0);
      check_value("overflow", int'(overflow), 1);
      check_path();

      // Second start while busy, then a short run after a long one.
      load_random_chain(`RECON_MAX_PATH - 1, gx, gy);
      run_trace(gx, gy, 6, 5, 7);
      check_path();
      load_random_chain(2, gx, gy);
      run_trace(gx, gy, 0, 0, 0);
      check_path();

      $display("Regression passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: project.f
+incdir+design
design/grid_pkg.sv
design/recon_pkg.sv
design/pred_table.sv
design/step_counter.sv
design/path_buffer.sv
design/recon_fsm.sv
design/path_recon.sv
testbench/tb_path_recon.sv

// File: Makefile
# Verilator build and run for the path reconstruction engine.
# Any variable below can be overridden, e.g. make sim TOP=tb_path_recon

VERILATOR ?= verilator
TOP       ?= tb_path_recon
SEED_LOG  ?= sim.log
FILE_LIST ?= project.f
BUILD_DIR ?= obj_dir
SIM_FLAGS ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILE_LIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILE_LIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(SEED_LOG)
	@if grep -q "Regression failed" $(SEED_LOG); then \
		echo "Simulation reported a failure, see $(SEED_LOG)"; exit 1; \
	fi
	@if ! grep -q "Regression passed" $(SEED_LOG); then \
		echo "Simulation ended without a result, see $(SEED_LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(SEED_LOG)
